//--- sources.f
source/sdram_pkg.sv
source/rom_slot.sv
source/slot_decode.sv
source/bank_arbiter.sv
source/result_steer.sv
source/game_sdram.sv
tests/sdram_model.sv
tests/tb_game_sdram.sv

//--- Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_game_sdram -f sources.f
	./obj_dir/Vtb_game_sdram | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/tb_game_sdram.sv
// ROM access subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_game_sdram;

    localparam int wait_limit  = 200;
    localparam int single_reads = 8;
    localparam int dual_rounds = 32;

    logic                          clk;
    logic                          rst;
    logic                          main_cs;
    logic [sdram_pkg::main_aw-1:0] main_addr;
    sdram_pkg::half_t              main_data;
    logic                          main_ok;
    logic                          char_cs;
    logic [sdram_pkg::char_aw-1:0] char_addr;
    sdram_pkg::word_t              char_data;
    logic                          char_ok;
    logic                          sdram_req;
    sdram_pkg::sdram_addr_t        sdram_addr;
    logic                          sdram_ack;
    sdram_pkg::word_t              sdram_data;
    logic [2:0]                    ack_delay;

    logic [31:0] lfsr_state;
    logic        req_prev;
    int          req_rises;
    int          check_errors;
    int          addr_errors;
    int          rise_errors;
    int          ack_errors;
    int          map_errors;
    int          timeouts;
    int          tests_run;
    int          tests_failed;

    game_sdram dut_i (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .main_cs    ( main_cs    ),
        .main_addr  ( main_addr  ),
        .main_data  ( main_data  ),
        .main_ok    ( main_ok    ),
        .char_cs    ( char_cs    ),
        .char_addr  ( char_addr  ),
        .char_data  ( char_data  ),
        .char_ok    ( char_ok    ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .sdram_ack  ( sdram_ack  ),
        .sdram_data ( sdram_data )
    );

    sdram_model u_model (
        .clk   ( clk        ),
        .rst   ( rst        ),
        .req   ( sdram_req  ),
        .addr  ( sdram_addr ),
        .delay ( ack_delay  ),
        .ack   ( sdram_ack  ),
        .data  ( sdram_data )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Count SDRAM transactions by their rising req
    always @(posedge clk) begin
        if (rst) begin
            req_prev  <= 1'b0;
            req_rises <= 0;
        end else begin
            req_prev <= sdram_req;
            if (sdram_req && !req_prev) begin
                req_rises <= req_rises + 1;
            end
        end
    end

    // Four-phase handshake on the SDRAM side
    assert property (@(posedge clk) disable iff (rst)
        sdram_req && $past(sdram_req) |-> sdram_addr == $past(sdram_addr))
    else begin
        addr_errors++;
        $display("[FAIL] sdram_addr changed to %h while sdram_req was high", sdram_addr);
    end

    assert property (@(posedge clk) disable iff (rst) $rose(sdram_req) |-> !sdram_ack)
    else begin
        rise_errors++;
        $display("sdram_req rose while sdram_ack was still high");
    end

    assert property (@(posedge clk) disable iff (rst) $rose(sdram_ack) |-> sdram_req)
    else begin
        ack_errors++;
        $display("sdram_ack rose with no sdram_req pending");
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int n = 0; n < count; n++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    // Region mapping in SDRAM words
    function automatic sdram_pkg::sdram_addr_t main_target(
        input logic [sdram_pkg::main_aw-1:0] a
    );
        return sdram_pkg::main_base + sdram_pkg::sdram_addr_t'(a >> 1);
    endfunction

    function automatic sdram_pkg::sdram_addr_t char_target(
        input logic [sdram_pkg::char_aw-1:0] a
    );
        return sdram_pkg::char_base + sdram_pkg::sdram_addr_t'(a);
    endfunction

    // Upper half inverted, lower half the address itself
    function automatic sdram_pkg::word_t model_word(input sdram_pkg::sdram_addr_t a);
        return {~a[15:0], a[15:0]};
    endfunction

    function automatic sdram_pkg::half_t expected_main(input logic [sdram_pkg::main_aw-1:0] a);
        sdram_pkg::word_t w;
        w = model_word(main_target(a));
        return a[0] ? w[31:16] : w[15:0];
    endfunction

    function automatic sdram_pkg::word_t expected_char(input logic [sdram_pkg::char_aw-1:0] a);
        return model_word(char_target(a));
    endfunction

    // Every SDRAM read goes to the region address of a waiting client
    assert property (@(posedge clk) disable iff (rst) $rose(sdram_req) |->
        (main_cs && sdram_addr == main_target(main_addr)) ||
        (char_cs && sdram_addr == char_target(char_addr)))
    else begin
        map_errors++;
        $display("[FAIL] sdram_addr %h matches neither main %h nor char %h", sdram_addr,
                 main_target(main_addr), char_target(char_addr));
    end

    function automatic int total_errors();
        return check_errors + addr_errors + rise_errors + ack_errors + map_errors + timeouts;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timed out waiting for %s", what);
    endtask

    task automatic check_main(input sdram_pkg::half_t want);
        assert (main_data == want) else begin
            check_errors++;
            $display("[FAIL] main_data at %h: got %h, expected %h", main_addr, main_data, want);
        end
    endtask

    task automatic check_char(input sdram_pkg::word_t want);
        assert (char_data == want) else begin
            check_errors++;
            $display("[FAIL] char_data at %h: got %h, expected %h", char_addr, char_data, want);
        end
    endtask

    task automatic check_waited(input string client, input int start);
        assert (req_rises - start <= 2) else begin
            check_errors++;
            $display("%s client waited for %0d SDRAM transactions", client, req_rises - start);
        end
    endtask

    // Raise the selected chip selects and wait for each ok on its own
    task automatic read_clients(input logic use_main, input logic use_char,
                                input logic [sdram_pkg::main_aw-1:0] ma,
                                input logic [sdram_pkg::char_aw-1:0] ca);
        logic main_seen;
        logic char_seen;
        int   start;
        int   cycles;
        main_seen = !use_main;
        char_seen = !use_char;
        start     = req_rises;
        cycles    = 0;
        main_addr = ma;
        char_addr = ca;
        main_cs   = use_main;
        char_cs   = use_char;
        while (!(main_seen && char_seen) && cycles < wait_limit) begin
            next_cycle();
            cycles++;
            if (!main_seen && main_ok) begin
                main_seen = 1'b1;
                check_main(expected_main(ma));
                check_waited("main", start);
                main_cs = 1'b0;
            end
            if (!char_seen && char_ok) begin
                char_seen = 1'b1;
                check_char(expected_char(ca));
                check_waited("char", start);
                char_cs = 1'b0;
            end
        end
        if (!main_seen) begin
            report_timeout("main_ok");
        end
        if (!char_seen) begin
            report_timeout("char_ok");
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (total_errors() == errors_before) begin
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s FAILED, %0d errors", name, total_errors() - errors_before);
        end
    endtask

    initial begin
        int                            i;
        int                            mark;
        int                            rises_before;
        logic [31:0]                   r;
        logic [sdram_pkg::main_aw-1:0] last_main;
        logic [sdram_pkg::char_aw-1:0] last_char;
        lfsr_state   = 32'h3ec9_249d;
        check_errors = 0;
        addr_errors  = 0;
        rise_errors  = 0;
        ack_errors   = 0;
        map_errors   = 0;
        timeouts     = 0;
        tests_run    = 0;
        tests_failed = 0;
        last_main    = '0;
        last_char    = '0;
        rst          = 1'b1;
        main_cs      = 1'b0;
        main_addr    = '0;
        char_cs      = 1'b0;
        char_addr    = '0;
        ack_delay    = 3'd0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Quiet after reset with no chip select
        mark = total_errors();
        repeat (10) begin
            assert (!sdram_req && !main_ok && !char_ok) else begin
                check_errors++;
                $display("sdram_req, main_ok or char_ok went high with no cs raised");
            end
            next_cycle();
        end
        end_test("reset_idle", mark);

        // Main reads, alternating halves
        mark = total_errors();
        for (i = 0; i < single_reads && timeouts == 0; i++) begin
            r         = random_bits(sdram_pkg::main_aw);
            last_main = r[sdram_pkg::main_aw-1:0];
            last_main[0] = i[0];
            r         = random_bits(3);
            ack_delay = r[2:0];
            read_clients(1'b1, 1'b0, last_main, last_char);
        end
        end_test("main_read", mark);

        mark = total_errors();
        for (i = 0; i < single_reads && timeouts == 0; i++) begin
            r         = random_bits(sdram_pkg::char_aw);
            last_char = r[sdram_pkg::char_aw-1:0];
            r         = random_bits(3);
            ack_delay = r[2:0];
            read_clients(1'b0, 1'b1, last_main, last_char);
        end
        end_test("char_read", mark);

        // Both slots still hold their last word
        mark = total_errors();
        next_cycle();
        rises_before = req_rises;
        main_addr    = last_main;
        char_addr    = last_char;
        main_cs      = 1'b1;
        char_cs      = 1'b1;
        next_cycle();
        assert (main_ok && char_ok) else begin
            check_errors++;
            $display("ok did not rise on the cycle after a re-read");
        end
        check_main(expected_main(last_main));
        check_char(expected_char(last_char));
        repeat (3) next_cycle();
        assert (req_rises == rises_before) else begin
            check_errors++;
            $display("a re-read of a stored word started an SDRAM transaction");
        end
        main_cs = 1'b0;
        char_cs = 1'b0;
        next_cycle();
        end_test("reread_hit", mark);

        mark = total_errors();
        for (i = 0; i < dual_rounds && timeouts == 0; i++) begin
            r         = random_bits(sdram_pkg::main_aw);
            last_main = r[sdram_pkg::main_aw-1:0];
            r         = random_bits(sdram_pkg::char_aw);
            last_char = r[sdram_pkg::char_aw-1:0];
            r         = random_bits(3);
            ack_delay = r[2:0];
            read_clients(1'b1, 1'b1, last_main, last_char);
        end
        end_test("dual_read", mark);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/sdram_model.sv
// Behavioral SDRAM read responder
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         req,
    input  wire sdram_pkg::sdram_addr_t addr,
    // Cycles to wait before ack, 0 to 7
    input  wire [2:0]                   delay,
    output logic                        ack,
    output sdram_pkg::word_t            data
);

    logic       busy;
    logic [2:0] left;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack  <= 1'b0;
            busy <= 1'b0;
            left <= 3'd0;
            data <= '0;
        end else if (ack) begin
            // Hold ack until the requester lets go of req
            if (!req) begin
                ack <= 1'b0;
            end
        end else if (busy) begin
            if (left == 3'd0) begin
                ack  <= 1'b1;
                busy <= 1'b0;
                data <= {~addr[15:0], addr[15:0]};
            end else begin
                left <= left - 3'd1;
            end
        end else if (req) begin
            if (delay == 3'd0) begin
                ack  <= 1'b1;
                data <= {~addr[15:0], addr[15:0]};
            end else begin
                busy <= 1'b1;
                left <= delay - 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/game_sdram.sv
// Game ROM access subsystem
`timescale 1ns/1ps
`default_nettype none

module game_sdram (
    input  wire                              clk,
    input  wire                              rst,
    // Main CPU ROM
    input  wire                              main_cs,
    input  wire [sdram_pkg::main_aw-1:0]     main_addr,
    output wire sdram_pkg::half_t            main_data,
    output wire                              main_ok,
    // Character ROM
    input  wire                              char_cs,
    input  wire [sdram_pkg::char_aw-1:0]     char_addr,
    output wire sdram_pkg::word_t            char_data,
    output wire                              char_ok,
    // SDRAM read port
    output wire                              sdram_req,
    output wire sdram_pkg::sdram_addr_t      sdram_addr,
    input  wire                              sdram_ack,
    input  wire sdram_pkg::word_t            sdram_data
);

    // Slot fetch requests
    wire                             main_fetch;
    wire [sdram_pkg::main_aw-1:0]    main_fetch_addr;
    wire                             char_fetch;
    wire [sdram_pkg::char_aw-1:0]    char_fetch_addr;

    // Decoded addresses
    wire sdram_pkg::sdram_addr_t     main_sdram_addr;
    wire                             main_half;
    wire sdram_pkg::sdram_addr_t     char_sdram_addr;

    // Arbiter results
    wire                             done;
    wire                             served;
    wire                             served_half;
    wire sdram_pkg::word_t           word;

    // Fills
    wire                             main_fill;
    wire sdram_pkg::half_t           main_fill_data;
    wire                             char_fill;
    wire sdram_pkg::word_t           char_fill_data;

    rom_slot #(
        .data_t     ( sdram_pkg::half_t  ),
        .aw         ( sdram_pkg::main_aw )
    ) u_main_slot (
        .clk        ( clk             ),
        .rst        ( rst             ),
        .cs         ( main_cs         ),
        .addr       ( main_addr       ),
        .data       ( main_data       ),
        .ok         ( main_ok         ),
        .fetch_req  ( main_fetch      ),
        .fetch_addr ( main_fetch_addr ),
        .fill       ( main_fill       ),
        .fill_data  ( main_fill_data  )
    );

    rom_slot #(
        .data_t     ( sdram_pkg::word_t  ),
        .aw         ( sdram_pkg::char_aw )
    ) u_char_slot (
        .clk        ( clk             ),
        .rst        ( rst             ),
        .cs         ( char_cs         ),
        .addr       ( char_addr       ),
        .data       ( char_data       ),
        .ok         ( char_ok         ),
        .fetch_req  ( char_fetch      ),
        .fetch_addr ( char_fetch_addr ),
        .fill       ( char_fill       ),
        .fill_data  ( char_fill_data  )
    );

    slot_decode u_decode (
        .main_fetch_addr ( main_fetch_addr ),
        .char_fetch_addr ( char_fetch_addr ),
        .main_sdram_addr ( main_sdram_addr ),
        .main_half       ( main_half       ),
        .char_sdram_addr ( char_sdram_addr )
    );

    bank_arbiter u_arbiter (
        .clk             ( clk             ),
        .rst             ( rst             ),
        .main_fetch      ( main_fetch      ),
        .char_fetch      ( char_fetch      ),
        .main_sdram_addr ( main_sdram_addr ),
        .main_half       ( main_half       ),
        .char_sdram_addr ( char_sdram_addr ),
        .sdram_req       ( sdram_req       ),
        .sdram_addr      ( sdram_addr      ),
        .sdram_ack       ( sdram_ack       ),
        .sdram_data      ( sdram_data      ),
        .done            ( done            ),
        .served          ( served          ),
        .served_half     ( served_half     ),
        .word            ( word            )
    );

    result_steer u_result (
        .clk             ( clk             ),
        .rst             ( rst             ),
        .done            ( done            ),
        .served          ( served          ),
        .served_half     ( served_half     ),
        .word            ( word            ),
        .main_fill       ( main_fill       ),
        .main_fill_data  ( main_fill_data  ),
        .char_fill       ( char_fill       ),
        .char_fill_data  ( char_fill_data  )
    );

endmodule

`default_nettype wire

//--- source/result_steer.sv
// Read data steering to client slots
`timescale 1ns/1ps
`default_nettype none

module result_steer (
    input  wire                   clk,
    input  wire                   rst,
    // From the arbiter
    input  wire                   done,
    input  wire                   served,
    input  wire                   served_half,
    input  wire sdram_pkg::word_t word,
    // Main CPU slot
    output logic                  main_fill,
    output sdram_pkg::half_t      main_fill_data,
    // Character slot
    output logic                  char_fill,
    output sdram_pkg::word_t      char_fill_data
);

    sdram_pkg::half_t main_lane;

    // Half select picks the CPU word inside the SDRAM word
    assign main_lane = served_half ? word[31:16] : word[15:0];

    // One fill pulse, only toward the client that was served
    always_ff @(posedge clk) begin
        if (rst) begin
            main_fill <= 1'b0;
            char_fill <= 1'b0;
        end else begin
            main_fill <= done && served == sdram_pkg::client_main;
            char_fill <= done && served == sdram_pkg::client_char;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            main_fill_data <= main_lane;
            char_fill_data <= word;
        end
    end

endmodule

`default_nettype wire

//--- source/bank_arbiter.sv
// Round-robin SDRAM read arbiter
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter (
    input  wire                         clk,
    input  wire                         rst,
    // Pending fetches and their decoded addresses
    input  wire                         main_fetch,
    input  wire                         char_fetch,
    input  wire sdram_pkg::sdram_addr_t main_sdram_addr,
    input  wire                         main_half,
    input  wire sdram_pkg::sdram_addr_t char_sdram_addr,
    // SDRAM read port
    output logic                        sdram_req,
    output sdram_pkg::sdram_addr_t      sdram_addr,
    input  wire                         sdram_ack,
    input  wire sdram_pkg::word_t       sdram_data,
    // Toward the result stage
    output logic                        done,
    output logic                        served,
    output logic                        served_half,
    output sdram_pkg::word_t            word
);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_release,
        st_done
    } state_t;

    state_t state;
    logic   prio;
    logic   settle;
    logic   main_want;
    logic   char_want;
    logic   pick_main;
    logic   grant;

    // Served slot still shows fetch_req while its fill is in flight
    assign main_want = main_fetch && !(settle && served == sdram_pkg::client_main);
    assign char_want = char_fetch && !(settle && served == sdram_pkg::client_char);

    // prio names the client that wins a tie
    assign pick_main = main_want && (!char_want || prio == sdram_pkg::client_main);
    assign grant     = state == st_idle && (main_want || char_want);

    assign done = state == st_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            sdram_req <= 1'b0;
            prio      <= sdram_pkg::client_main;
            settle    <= 1'b0;
        end else begin
            settle <= state == st_done;
            case (state)
                st_idle: begin
                    if (grant) begin
                        sdram_req <= 1'b1;
                        state     <= st_request;
                    end
                end
                st_request: begin
                    // Data is valid with ack
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= st_release;
                    end
                end
                st_release: begin
                    if (!sdram_ack) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    // Other client wins the next tie
                    prio  <= ~served;
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Grant and capture registers
    always_ff @(posedge clk) begin
        if (grant) begin
            served      <= pick_main ? sdram_pkg::client_main : sdram_pkg::client_char;
            served_half <= pick_main ? main_half : 1'b0;
            sdram_addr  <= pick_main ? main_sdram_addr : char_sdram_addr;
        end
        if (state == st_request && sdram_ack) begin
            word <= sdram_data;
        end
    end

endmodule

`default_nettype wire

//--- source/slot_decode.sv
// Client region address decoder
`timescale 1ns/1ps
`default_nettype none

module slot_decode (
    input  wire [sdram_pkg::main_aw-1:0] main_fetch_addr,
    input  wire [sdram_pkg::char_aw-1:0] char_fetch_addr,
    // Main CPU region
    output sdram_pkg::sdram_addr_t       main_sdram_addr,
    output logic                         main_half,
    // Character region
    output sdram_pkg::sdram_addr_t       char_sdram_addr
);

    sdram_pkg::sdram_addr_t main_offset;
    sdram_pkg::sdram_addr_t char_offset;

    // Two 16-bit CPU words share one SDRAM word
    assign main_offset = sdram_pkg::sdram_addr_t'(main_fetch_addr[sdram_pkg::main_aw-1:1]);

    // Odd CPU word sits in the upper half
    assign main_half = main_fetch_addr[0];

    assign main_sdram_addr = sdram_pkg::main_base + main_offset;

    // Tile words are already 32 bits wide
    assign char_offset = sdram_pkg::sdram_addr_t'(char_fetch_addr);

    assign char_sdram_addr = sdram_pkg::char_base + char_offset;

endmodule

`default_nettype wire

//--- source/rom_slot.sv
// One-entry ROM client slot
`timescale 1ns/1ps
`default_nettype none

module rom_slot #(
    parameter type data_t = sdram_pkg::half_t,
    parameter int  aw     = sdram_pkg::main_aw
) (
    input  wire            clk,
    input  wire            rst,
    // Client side
    input  wire            cs,
    input  wire [aw-1:0]   addr,
    output data_t          data,
    output logic           ok,
    // Fetch side
    output logic           fetch_req,
    output logic [aw-1:0]  fetch_addr,
    input  wire            fill,
    input  wire data_t     fill_data
);

    data_t data_q;
    logic  valid;
    logic  ok_q;
    logic  match;
    logic  miss;

    // Stored address doubles as the fetch address
    assign match = addr == fetch_addr;

    // Only one fetch outstanding per slot
    assign miss = cs && !fetch_req && (!valid || !match);

    // Never show ok for an address the entry does not hold
    assign ok   = ok_q && cs && match;
    assign data = data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid     <= 1'b0;
            fetch_req <= 1'b0;
            ok_q      <= 1'b0;
        end else begin
            // Hit on a valid entry, or a fill landing on the current address
            ok_q <= cs && match && (valid || fill);
            if (miss) begin
                valid     <= 1'b0;
                fetch_req <= 1'b1;
            end else if (fill && fetch_req) begin
                valid     <= 1'b1;
                fetch_req <= 1'b0;
            end
        end
    end

    // Entry address and payload
    always_ff @(posedge clk) begin
        if (miss) begin
            fetch_addr <= addr;
        end
        if (fill && fetch_req) begin
            data_q <= fill_data;
        end
    end

endmodule

`default_nettype wire

//--- source/sdram_pkg.sv
// ROM access shared definitions
`default_nettype none

package sdram_pkg;

    // Address widths, all counted in words of the client's own size
    localparam int sdram_aw = 20;
    localparam int main_aw  = 17;
    localparam int char_aw  = 13;

    // Payloads
    typedef logic [15:0] half_t;
    typedef logic [31:0] word_t;

    // SDRAM side addresses 32-bit words
    typedef logic [sdram_aw-1:0] sdram_addr_t;

    // Region bases in the SDRAM word space
    localparam sdram_addr_t main_base = 20'h00000;
    localparam sdram_addr_t char_base = 20'h80000;

    // Client indices shared by arbitration and steering
    localparam logic client_main = 1'b0;
    localparam logic client_char = 1'b1;

endpackage

`default_nettype wire
